/* dv/mem_subsys_props.sv */
`timescale 1ns/1ps

module mem_subsys_props
  import mem_pkg::*;
(
  input logic  clock,
  input logic  reset,
  input logic  fetch_done,
  input logic  lsu_done,
  input logic  m_arvalid,
  input logic  m_arready,
  input addr_t m_araddr,
  input logic  m_awvalid,
  input logic  m_awready,
  input addr_t m_awaddr,
  input logic  m_wvalid,
  input logic  m_wready,
  input data_t m_wdata,
  input strb_t m_wstrb
);

  int fail_count = 0;

  // valid and payload held while the slave stalls
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
    else begin
      $error("read address dropped or changed while stalled");
      fail_count++;
    end

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr))
    else begin
      $error("write address dropped or changed while stalled");
      fail_count++;
    end

  w_hold: assert property (@(posedge clock) disable iff (reset)
    m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wstrb))
    else begin
      $error("write data dropped or changed while stalled");
      fail_count++;
    end

  // done strobes are single cycle
  fetch_pulse: assert property (@(posedge clock) disable iff (reset)
    fetch_done |=> !fetch_done)
    else begin
      $error("fetch_done held longer than one cycle");
      fail_count++;
    end

  lsu_pulse: assert property (@(posedge clock) disable iff (reset)
    lsu_done |=> !lsu_done)
    else begin
      $error("lsu_done held longer than one cycle");
      fail_count++;
    end

  // clint accesses never leak onto the master bus
  ar_not_clint: assert property (@(posedge clock) disable iff (reset)
    m_arvalid |-> (m_araddr & CLINT_MASK) != CLINT_BASE)
    else begin
      $error("clint read address seen on the master bus");
      fail_count++;
    end

  aw_not_clint: assert property (@(posedge clock) disable iff (reset)
    m_awvalid |-> (m_awaddr & CLINT_MASK) != CLINT_BASE)
    else begin
      $error("clint write address seen on the master bus");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clock)
    $fell(reset) |-> !fetch_done && !lsu_done && !m_arvalid && !m_awvalid && !m_wvalid)
    else begin
      $error("outputs active right after reset");
      fail_count++;
    end

endmodule

bind mem_subsys_top mem_subsys_props mem_subsys_props_inst (
  .clock      (clock),
  .reset      (reset),
  .fetch_done (fetch_done),
  .lsu_done   (lsu_done),
  .m_arvalid  (m_arvalid),
  .m_arready  (m_arready),
  .m_araddr   (m_araddr),
  .m_awvalid  (m_awvalid),
  .m_awready  (m_awready),
  .m_awaddr   (m_awaddr),
  .m_wvalid   (m_wvalid),
  .m_wready   (m_wready),
  .m_wdata    (m_wdata),
  .m_wstrb    (m_wstrb)
);

/* dv/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys
  import mem_pkg::*;
();

  localparam int LIMIT = 200;

  logic  clock = 1'b0;
  logic  reset = 1'b1;
  logic  fetch_start = 1'b0;
  addr_t fetch_pc = '0;
  logic  lsu_start = 1'b0;
  logic  lsu_write = 1'b0;
  func_t lsu_func = FUNC_W;
  addr_t lsu_addr = '0;
  data_t lsu_wdata = '0;
  logic  m_arready = 1'b0;
  logic  m_rvalid = 1'b0;
  data_t m_rdata = '0;
  logic  m_awready = 1'b0;
  logic  m_wready = 1'b0;
  logic  m_bvalid = 1'b0;
  resp_t m_rresp;
  resp_t m_bresp;
  logic  fetch_done, lsu_done, lsu_err, m_arvalid, m_rready;
  logic  m_awvalid, m_wvalid, m_bready;
  data_t fetch_inst, lsu_rdata, m_wdata;
  addr_t m_araddr, m_awaddr;
  strb_t m_wstrb;

  integer seed = 32'hc265;
  data_t  mem [0:255];
  int     cycles, t_start, t_done, aw_total, ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic   rd_pend, rd_open, aw_got, w_got;
  addr_t  rd_addr, wr_addr;
  data_t  wr_data;
  strb_t  wr_strb;
  addr_t  ar_log [$];

  assign m_rresp = RESP_OKAY;
  assign m_bresp = RESP_OKAY;

  mem_subsys_top mem_subsys_top_inst (.*);

  always #10 clock = ~clock;

  // counts like mtime, zero in the first cycle out of reset
  always @(posedge clock) begin
    if (reset) cycles <= 0;
    else cycles <= cycles + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // a failed protocol property ends the run
  always @(posedge clock) begin
    if (mem_subsys_top_inst.mem_subsys_props_inst.fail_count != 0) begin
      abort_run("protocol property failed on the DUT ports");
    end
  end

  task automatic check_word(input string name, input data_t expected, input data_t actual);
    assert (actual === expected)
      else abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
  endtask

  function automatic data_t apply_strobe(data_t old, data_t wdata, strb_t strb);
    data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[i*8 +: 8] = wdata[i*8 +: 8];
    end
    return res;
  endfunction

  function automatic int access_bytes(func_t f);
    if (f[1:0] == 2'b00) return 1;
    if (f[1:0] == 2'b01) return 2;
    return 4;
  endfunction

  function automatic data_t load_expect(data_t word, logic [1:0] off, func_t f);
    data_t sel;
    sel = word >> (8 * off);
    case (f)
      FUNC_B:  return {{24{sel[7]}}, sel[7:0]};
      FUNC_H:  return {{16{sel[15]}}, sel[15:0]};
      FUNC_BU: return {24'd0, sel[7:0]};
      FUNC_HU: return {16'd0, sel[15:0]};
      default: return sel;
    endcase
  endfunction

  // store bytes land at the offset, the rest of the word stays
  function automatic data_t store_expect(data_t old, data_t wdata, logic [1:0] off, func_t f);
    data_t res;
    res = old;
    for (int i = 0; i < access_bytes(f); i++) res[(off + i) * 8 +: 8] = wdata[i*8 +: 8];
    return res;
  endfunction

  // read slave, one access at a time with random stalls
  always @(posedge clock) begin
    if (reset) begin
      m_arready <= 1'b0;
      m_rvalid  <= 1'b0;
      rd_pend   <= 1'b0;
      ar_wait   <= 0;
      r_wait    <= 0;
    end else begin
      if (m_arvalid && m_arready) begin
        m_arready <= 1'b0;
        rd_pend   <= 1'b1;
        rd_addr   <= m_araddr;
        r_wait    <= $random(seed) & 3;
      end else if (m_arvalid && !rd_pend && !m_rvalid) begin
        if (ar_wait == 0) m_arready <= 1'b1;
        else ar_wait <= ar_wait - 1;
      end else begin
        ar_wait <= $random(seed) & 3;
      end
      if (m_rvalid && m_rready) begin
        m_rvalid <= 1'b0;
      end else if (rd_pend && !m_rvalid) begin
        if (r_wait == 0) begin
          m_rvalid <= 1'b1;
          m_rdata  <= mem[rd_addr[9:2]];
          rd_pend  <= 1'b0;
        end else begin
          r_wait <= r_wait - 1;
        end
      end
    end
  end

  // write slave, memory takes the strobed lanes when the response goes out
  always @(posedge clock) begin
    if (reset) begin
      m_awready <= 1'b0;
      m_wready  <= 1'b0;
      m_bvalid  <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      aw_wait   <= 0;
      w_wait    <= 0;
      b_wait    <= 0;
    end else begin
      if (m_awvalid && m_awready) begin
        m_awready <= 1'b0;
        aw_got    <= 1'b1;
        wr_addr   <= m_awaddr;
      end else if (m_awvalid && !aw_got) begin
        if (aw_wait == 0) m_awready <= 1'b1;
        else aw_wait <= aw_wait - 1;
      end else begin
        aw_wait <= $random(seed) & 3;
      end
      if (m_wvalid && m_wready) begin
        m_wready <= 1'b0;
        w_got    <= 1'b1;
        wr_data  <= m_wdata;
        wr_strb  <= m_wstrb;
      end else if (m_wvalid && !w_got) begin
        if (w_wait == 0) m_wready <= 1'b1;
        else w_wait <= w_wait - 1;
      end else begin
        w_wait <= $random(seed) & 3;
      end
      if (m_bvalid && m_bready) begin
        m_bvalid <= 1'b0;
      end else if (aw_got && w_got && !m_bvalid) begin
        if (b_wait == 0) begin
          mem[wr_addr[9:2]] <= apply_strobe(mem[wr_addr[9:2]], wr_data, wr_strb);
          m_bvalid <= 1'b1;
          aw_got   <= 1'b0;
          w_got    <= 1'b0;
          b_wait   <= $random(seed) & 3;
        end else begin
          b_wait <= b_wait - 1;
        end
      end
    end
  end

  // one read in flight on the master bus at most
  always @(posedge clock) begin
    if (reset) begin
      rd_open  <= 1'b0;
      aw_total <= 0;
    end else begin
      if (m_awvalid) aw_total <= aw_total + 1;
      if (m_arvalid) begin
        assert (!rd_open) else abort_run("second read address issued before read data returned");
      end
      if (m_arvalid && m_arready) begin
        ar_log.push_back(m_araddr);
        rd_open <= 1'b1;
      end else if (m_rvalid && m_rready) begin
        rd_open <= 1'b0;
      end
    end
  end

  task automatic fetch_word(input addr_t pc, output data_t inst);
    int n;
    @(posedge clock);
    fetch_start <= 1'b1;
    fetch_pc    <= pc;
    @(posedge clock);
    fetch_start <= 1'b0;
    n = 0;
    @(negedge clock);
    while (!fetch_done) begin
      if (n == LIMIT) abort_run("timed out waiting for fetch_done");
      n++;
      @(negedge clock);
    end
    inst = fetch_inst;
  endtask

  task automatic lsu_access(input logic write, input func_t func, input addr_t addr,
                            input data_t wdata, output data_t rdata, output logic err);
    int n;
    @(posedge clock);
    lsu_start <= 1'b1;
    lsu_write <= write;
    lsu_func  <= func;
    lsu_addr  <= addr;
    lsu_wdata <= wdata;
    @(negedge clock);
    t_start = cycles;
    @(posedge clock);
    lsu_start <= 1'b0;
    n = 0;
    @(negedge clock);
    while (!lsu_done) begin
      if (n == LIMIT) abort_run("timed out waiting for lsu_done");
      n++;
      @(negedge clock);
    end
    t_done = cycles;
    rdata  = lsu_rdata;
    err    = lsu_err;
  endtask

  // fetch and load issued in the same cycle
  task automatic fetch_and_load(input addr_t pc, input addr_t addr);
    int   n;
    logic got_fetch;
    logic got_load;
    ar_log.delete();
    got_fetch = 1'b0;
    got_load  = 1'b0;
    n = 0;
    @(posedge clock);
    fetch_start <= 1'b1;
    fetch_pc    <= pc;
    lsu_start   <= 1'b1;
    lsu_write   <= 1'b0;
    lsu_func    <= FUNC_W;
    lsu_addr    <= addr;
    @(posedge clock);
    fetch_start <= 1'b0;
    lsu_start   <= 1'b0;
    while (!(got_fetch && got_load)) begin
      if (n == LIMIT) abort_run("timed out waiting for fetch and load to finish");
      n++;
      @(negedge clock);
      if (fetch_done) begin
        got_fetch = 1'b1;
        check_word("arb_fetch", mem[pc[9:2]], fetch_inst);
      end
      if (lsu_done) begin
        got_load = 1'b1;
        check_word("arb_load", mem[addr[9:2]], lsu_rdata);
      end
    end
    check_word("arb_count", 32'd2, ar_log.size());
    check_word("arb_order", addr, ar_log[0]);
  endtask

  initial begin
    int    k;
    int    off;
    addr_t pc, addr;
    data_t word, old, wdata, lo_first, lo_second;
    logic  err;
    for (int i = 0; i < 256; i++) mem[i] = (i * 4 + 1) * 32'h9e37_79b1 ^ 32'h5a5a_a5a5;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    for (k = 0; k < 8; k++) begin
      pc = $random(seed) & 32'h0000_03fc;
      fetch_word(pc, word);
      check_word($sformatf("fetch pc %h", pc), mem[pc[9:2]], word);
    end

    // loads, every code at each aligned offset
    k = 0;
    for (int f = 0; f < 6; f++) begin
      for (off = 0; off < 4; off++) begin
        if (f != 3 && off % access_bytes(func_t'(f)) == 0) begin
          addr = 32'h100 + k * 4 + off;
          k++;
          lsu_access(1'b0, func_t'(f), addr, '0, word, err);
          check_word($sformatf("load f%0d off%0d", f, off),
                     load_expect(mem[addr[9:2]], addr[1:0], func_t'(f)), word);
          check_word("load_err", '0, data_t'(err));
        end
      end
    end

    // sb, sh and sw, each read back as a word
    for (int f = 0; f < 3; f++) begin
      for (off = 0; off < 4; off++) begin
        if (off % access_bytes(func_t'(f)) == 0) begin
          addr  = 32'h200 + k * 4 + off;
          k++;
          old   = mem[addr[9:2]];
          wdata = $random(seed);
          lsu_access(1'b1, func_t'(f), addr, wdata, word, err);
          check_word("store_err", '0, data_t'(err));
          lsu_access(1'b0, FUNC_W, {addr[31:2], 2'b00}, '0, word, err);
          check_word($sformatf("store f%0d off%0d", f, off),
                     store_expect(old, wdata, addr[1:0], func_t'(f)), word);
        end
      end
    end

    fetch_and_load(32'h010, 32'h300);
    fetch_and_load($random(seed) & 32'h0000_03fc, 32'h344);

    // mtime reads
    lsu_access(1'b0, FUNC_W, CLINT_BASE, '0, lo_first, err);
    assert (lo_first >= t_start && lo_first <= t_done)
      else abort_run($sformatf("MISMATCH clint_lo expected %0d to %0d actual %0d",
                               t_start, t_done, lo_first));
    check_word("clint_lo_err", '0, data_t'(err));
    lsu_access(1'b0, FUNC_W, CLINT_BASE, '0, lo_second, err);
    assert (lo_second > lo_first)
      else abort_run($sformatf("MISMATCH clint_rise expected above %0d actual %0d",
                               lo_first, lo_second));
    lsu_access(1'b0, FUNC_W, CLINT_BASE + 4, '0, word, err);
    check_word("clint_hi", '0, word);
    k = aw_total;
    lsu_access(1'b1, FUNC_W, CLINT_BASE, 32'h1234_5678, word, err);
    check_word("clint_store_err", 32'd1, data_t'(err));
    check_word("clint_store_aw", k, aw_total);

    if (mem_subsys_top_inst.mem_subsys_props_inst.fail_count != 0) begin
      abort_run("protocol property failed on the DUT ports");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

/* files.f */
rtl/mem_pkg.sv
rtl/axi_rd_if.sv
rtl/axi_wr_if.sv
rtl/fetch_unit.sv
rtl/lsu_align.sv
rtl/bus_arbiter.sv
rtl/addr_xbar.sv
rtl/clint_timer.sv
rtl/mem_subsys_top.sv
dv/mem_subsys_props.sv
dv/tb_mem_subsys.sv

/* rtl/addr_xbar.sv */
`timescale 1ns/1ps

module addr_xbar
  import mem_pkg::*;
(
  input  logic clock,
  input  logic reset,
  axi_rd_if.slave  rd_in,
  axi_wr_if.slave  wr_in,
  axi_rd_if.master rd_ext,
  axi_wr_if.master wr_ext,
  axi_rd_if.master rd_clint
);

  logic rd_hit_clint;
  logic rd_busy;
  logic rd_tgt_clint;
  logic wr_hit_clint;
  logic wr_sel_clint;
  logic aw_seen;
  logic w_seen;
  logic wr_tgt_clint;
  logic err_bvalid;
  logic aw_xfer;
  logic w_xfer;
  logic b_xfer;

  assign rd_hit_clint = (rd_in.araddr & CLINT_MASK) == CLINT_BASE;
  assign wr_hit_clint = (wr_in.awaddr & CLINT_MASK) == CLINT_BASE;

  // read address by decode, read data by the latched target
  assign rd_ext.araddr    = rd_in.araddr;
  assign rd_clint.araddr  = rd_in.araddr;
  assign rd_ext.arvalid   = rd_in.arvalid && !rd_busy && !rd_hit_clint;
  assign rd_clint.arvalid = rd_in.arvalid && !rd_busy && rd_hit_clint;
  assign rd_in.arready    = !rd_busy && (rd_hit_clint ? rd_clint.arready : rd_ext.arready);
  assign rd_in.rvalid     = rd_busy && (rd_tgt_clint ? rd_clint.rvalid : rd_ext.rvalid);
  assign rd_in.rdata      = rd_tgt_clint ? rd_clint.rdata : rd_ext.rdata;
  assign rd_in.rresp      = rd_tgt_clint ? rd_clint.rresp : rd_ext.rresp;
  assign rd_ext.rready    = rd_in.rready && rd_busy && !rd_tgt_clint;
  assign rd_clint.rready  = rd_in.rready && rd_busy && rd_tgt_clint;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_busy      <= 1'b0;
      rd_tgt_clint <= 1'b0;
    end else if (rd_in.arvalid && rd_in.arready) begin
      rd_busy      <= 1'b1;
      rd_tgt_clint <= rd_hit_clint;
    end else if (rd_in.rvalid && rd_in.rready) begin
      rd_busy <= 1'b0;
    end
  end

  // clint is read only, writes end here with slverr
  assign wr_sel_clint   = aw_seen ? wr_tgt_clint : wr_hit_clint;
  assign wr_ext.awaddr  = wr_in.awaddr;
  assign wr_ext.wdata   = wr_in.wdata;
  assign wr_ext.wstrb   = wr_in.wstrb;
  assign wr_ext.awvalid = wr_in.awvalid && !aw_seen && !wr_hit_clint;
  assign wr_ext.wvalid  = wr_in.wvalid && !w_seen && !wr_sel_clint;
  assign wr_in.awready  = !aw_seen && (wr_hit_clint || wr_ext.awready);
  assign wr_in.wready   = !w_seen && (wr_sel_clint || wr_ext.wready);
  assign wr_in.bvalid   = wr_sel_clint ? err_bvalid : wr_ext.bvalid;
  assign wr_in.bresp    = wr_sel_clint ? RESP_SLVERR : wr_ext.bresp;
  assign wr_ext.bready  = wr_in.bready && !wr_sel_clint;

  assign aw_xfer = wr_in.awvalid && wr_in.awready;
  assign w_xfer  = wr_in.wvalid && wr_in.wready;
  assign b_xfer  = wr_in.bvalid && wr_in.bready;

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_seen      <= 1'b0;
      w_seen       <= 1'b0;
      wr_tgt_clint <= 1'b0;
      err_bvalid   <= 1'b0;
    end else begin
      if (aw_xfer) begin
        aw_seen      <= 1'b1;
        wr_tgt_clint <= wr_hit_clint;
      end else if (b_xfer) begin
        aw_seen <= 1'b0;
      end
      if (w_xfer) begin
        w_seen <= 1'b1;
      end else if (b_xfer) begin
        w_seen <= 1'b0;
      end
      // error response a cycle after both halves are taken
      if (err_bvalid) begin
        if (wr_in.bready) err_bvalid <= 1'b0;
      end else if (wr_sel_clint && (aw_seen || aw_xfer) && (w_seen || w_xfer)) begin
        err_bvalid <= 1'b1;
      end
    end
  end

endmodule

/* rtl/axi_rd_if.sv */
`timescale 1ns/1ps

interface axi_rd_if
  import mem_pkg::*;
();

  // read address channel
  logic  arvalid;
  logic  arready;
  addr_t araddr;

  // read data channel
  logic  rvalid;
  logic  rready;
  data_t rdata;
  resp_t rresp;

  modport master (
    output arvalid, araddr, rready,
    input  arready, rvalid, rdata, rresp
  );

  modport slave (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata, rresp
  );

endinterface

/* rtl/axi_wr_if.sv */
`timescale 1ns/1ps

interface axi_wr_if
  import mem_pkg::*;
();

  // write address channel
  logic  awvalid;
  logic  awready;
  addr_t awaddr;

  // write data channel
  logic  wvalid;
  logic  wready;
  data_t wdata;
  strb_t wstrb;

  // write response channel
  logic  bvalid;
  logic  bready;
  resp_t bresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  awready, wready, bvalid, bresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output awready, wready, bvalid, bresp
  );

endinterface

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter
  import mem_pkg::*;
(
  input  logic clock,
  input  logic reset,
  axi_rd_if.slave  fetch_port,
  axi_rd_if.slave  lsu_port,
  axi_rd_if.master bus
);

  typedef enum logic [1:0] {IDLE, GRANT_FETCH, GRANT_LSU} state_t;

  state_t state;
  logic   own_fetch;
  logic   own_lsu;
  logic   rd_xfer;

  // load/store wins a tie while idle
  assign own_lsu   = (state == GRANT_LSU) || (state == IDLE && lsu_port.arvalid);
  assign own_fetch = (state == GRANT_FETCH) ||
                     (state == IDLE && !lsu_port.arvalid && fetch_port.arvalid);

  assign rd_xfer = bus.rvalid && bus.rready;

  // data is shared, rvalid picks the owner
  assign fetch_port.rdata = bus.rdata;
  assign fetch_port.rresp = bus.rresp;
  assign lsu_port.rdata   = bus.rdata;
  assign lsu_port.rresp   = bus.rresp;

  always_comb begin
    bus.arvalid        = 1'b0;
    bus.araddr         = fetch_port.araddr;
    bus.rready         = 1'b0;
    fetch_port.arready = 1'b0;
    fetch_port.rvalid  = 1'b0;
    lsu_port.arready   = 1'b0;
    lsu_port.rvalid    = 1'b0;
    if (own_lsu) begin
      bus.arvalid      = lsu_port.arvalid;
      bus.araddr       = lsu_port.araddr;
      bus.rready       = lsu_port.rready;
      lsu_port.arready = bus.arready;
      lsu_port.rvalid  = bus.rvalid;
    end else if (own_fetch) begin
      bus.arvalid        = fetch_port.arvalid;
      bus.araddr         = fetch_port.araddr;
      bus.rready         = fetch_port.rready;
      fetch_port.arready = bus.arready;
      fetch_port.rvalid  = bus.rvalid;
    end
  end

  // grant holds from the address request until the read data lands
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (lsu_port.arvalid) begin
            state <= GRANT_LSU;
          end else if (fetch_port.arvalid) begin
            state <= GRANT_FETCH;
          end
        end
        GRANT_FETCH: begin
          if (rd_xfer) state <= IDLE;
        end
        GRANT_LSU: begin
          if (rd_xfer) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* rtl/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer
  import mem_pkg::*;
#(
  parameter int MTIME_WIDTH = 64
) (
  input  logic clock,
  input  logic reset,
  axi_rd_if.slave bus
);

  logic [MTIME_WIDTH-1:0] mtime;
  logic [63:0]            mtime_full;
  logic                   rvalid_q;
  data_t                  rdata_q;

  // free running, zero in the first cycle out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  // narrower counters read back zero extended
  always_comb begin
    mtime_full                    = '0;
    mtime_full[MTIME_WIDTH-1:0]   = mtime;
  end

  assign bus.arready = !rvalid_q;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (bus.arvalid && bus.arready) begin
      rvalid_q <= 1'b1;
    end else if (bus.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // snapshot taken at the address transfer
  always_ff @(posedge clock) begin
    if (bus.arvalid && bus.arready) begin
      rdata_q <= bus.araddr[2] ? mtime_full[63:32] : mtime_full[31:0];
    end
  end

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
  import mem_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  fetch_start,
  input  addr_t fetch_pc,
  output logic  fetch_done,
  output data_t fetch_inst,
  axi_rd_if.master bus
);

  typedef enum logic {IDLE, WAIT} state_t;

  state_t state;
  logic   ar_pend;
  addr_t  pc_q;

  assign bus.arvalid = (state == WAIT) && ar_pend;
  assign bus.araddr  = pc_q;
  // data phase starts once the address is taken
  assign bus.rready  = (state == WAIT) && !ar_pend;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= IDLE;
      ar_pend    <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      case (state)
        IDLE: begin
          if (fetch_start) begin
            state   <= WAIT;
            ar_pend <= 1'b1;
          end
        end
        WAIT: begin
          if (bus.arvalid && bus.arready) begin
            ar_pend <= 1'b0;
          end
          if (bus.rvalid && bus.rready) begin
            state      <= IDLE;
            fetch_done <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && fetch_start) begin
      pc_q <= fetch_pc;
    end
    if (bus.rvalid && bus.rready) begin
      fetch_inst <= bus.rdata;
    end
  end

endmodule

/* rtl/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align
  import mem_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  lsu_start,
  input  logic  lsu_write,
  input  func_t lsu_func,
  input  addr_t lsu_addr,
  input  data_t lsu_wdata,
  output logic  lsu_done,
  output logic  lsu_err,
  output data_t lsu_rdata,
  axi_rd_if.master rd,
  axi_wr_if.master wr
);

  typedef enum logic [1:0] {IDLE, READ, WRITE} state_t;

  state_t     state;
  logic       ar_pend;
  logic       aw_pend;
  logic       w_pend;
  addr_t      addr_q;
  func_t      func_q;
  logic [1:0] off_q;
  data_t      wdata_q;
  strb_t      strb_q;
  strb_t      strb_next;
  data_t      rd_shift;
  data_t      load_val;

  // byte enables by access size, shifted to the lane
  always_comb begin
    case (lsu_func[1:0])
      2'b00:   strb_next = strb_t'(4'b0001 << lsu_addr[1:0]);
      2'b01:   strb_next = strb_t'(4'b0011 << lsu_addr[1:0]);
      default: strb_next = 4'b1111;
    endcase
  end

  // pull the addressed bytes down, then extend
  assign rd_shift = rd.rdata >> {off_q, 3'b000};

  always_comb begin
    case (func_q)
      FUNC_B:  load_val = {{24{rd_shift[7]}}, rd_shift[7:0]};
      FUNC_H:  load_val = {{16{rd_shift[15]}}, rd_shift[15:0]};
      FUNC_BU: load_val = {24'd0, rd_shift[7:0]};
      FUNC_HU: load_val = {16'd0, rd_shift[15:0]};
      FUNC_W:  load_val = rd_shift;
      default: load_val = rd_shift;
    endcase
  end

  assign rd.arvalid = (state == READ) && ar_pend;
  assign rd.araddr  = addr_q;
  assign rd.rready  = (state == READ) && !ar_pend;
  assign wr.awvalid = (state == WRITE) && aw_pend;
  assign wr.awaddr  = addr_q;
  assign wr.wvalid  = (state == WRITE) && w_pend;
  assign wr.wdata   = wdata_q;
  assign wr.wstrb   = strb_q;
  // response only once both address and data are gone
  assign wr.bready  = (state == WRITE) && !aw_pend && !w_pend;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= IDLE;
      ar_pend  <= 1'b0;
      aw_pend  <= 1'b0;
      w_pend   <= 1'b0;
      lsu_done <= 1'b0;
      lsu_err  <= 1'b0;
    end else begin
      lsu_done <= 1'b0;
      case (state)
        IDLE: begin
          if (lsu_start && lsu_write) begin
            state   <= WRITE;
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
          end else if (lsu_start) begin
            state   <= READ;
            ar_pend <= 1'b1;
          end
        end
        READ: begin
          if (rd.arvalid && rd.arready) ar_pend <= 1'b0;
          if (rd.rvalid && rd.rready) begin
            state    <= IDLE;
            lsu_done <= 1'b1;
            lsu_err  <= (rd.rresp != RESP_OKAY);
          end
        end
        WRITE: begin
          if (wr.awvalid && wr.awready) aw_pend <= 1'b0;
          if (wr.wvalid && wr.wready) w_pend <= 1'b0;
          if (wr.bvalid && wr.bready) begin
            state    <= IDLE;
            lsu_done <= 1'b1;
            lsu_err  <= (wr.bresp != RESP_OKAY);
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && lsu_start) begin
      addr_q  <= {lsu_addr[31:2], 2'b00};
      off_q   <= lsu_addr[1:0];
      func_q  <= lsu_func;
      wdata_q <= lsu_wdata << {lsu_addr[1:0], 3'b000};
      strb_q  <= strb_next;
    end
    if (rd.rvalid && rd.rready) begin
      lsu_rdata <= load_val;
    end
  end

endmodule

/* rtl/mem_pkg.sv */
package mem_pkg;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;
  typedef logic [2:0]  func_t;

  // axi response codes
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // access size and extension, riscv funct3 encoding
  localparam func_t FUNC_B  = 3'd0;
  localparam func_t FUNC_H  = 3'd1;
  localparam func_t FUNC_W  = 3'd2;
  localparam func_t FUNC_BU = 3'd4;
  localparam func_t FUNC_HU = 3'd5;

  // clint region, offset 0 is mtime low and offset 4 is mtime high
  localparam addr_t CLINT_BASE = 32'h0200_0000;
  localparam addr_t CLINT_MASK = 32'hFFFF_0000;

endpackage

/* rtl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top
  import mem_pkg::*;
#(
  parameter int MTIME_WIDTH = 64
) (
  input  logic  clock,
  input  logic  reset,
  // fetch side
  input  logic  fetch_start,
  input  addr_t fetch_pc,
  output logic  fetch_done,
  output data_t fetch_inst,
  // load/store side
  input  logic  lsu_start,
  input  logic  lsu_write,
  input  func_t lsu_func,
  input  addr_t lsu_addr,
  input  data_t lsu_wdata,
  output logic  lsu_done,
  output data_t lsu_rdata,
  output logic  lsu_err,
  // axi-lite master, read
  output logic  m_arvalid,
  input  logic  m_arready,
  output addr_t m_araddr,
  input  logic  m_rvalid,
  output logic  m_rready,
  input  data_t m_rdata,
  input  resp_t m_rresp,
  // axi-lite master, write
  output logic  m_awvalid,
  input  logic  m_awready,
  output addr_t m_awaddr,
  output logic  m_wvalid,
  input  logic  m_wready,
  output data_t m_wdata,
  output strb_t m_wstrb,
  input  logic  m_bvalid,
  output logic  m_bready,
  input  resp_t m_bresp
);

  axi_rd_if rd_fetch ();
  axi_rd_if rd_lsu ();
  axi_wr_if wr_lsu ();
  axi_rd_if rd_bus ();
  axi_rd_if rd_ext ();
  axi_wr_if wr_ext ();
  axi_rd_if rd_clint ();

  fetch_unit fetch_unit_inst (
    .clock       (clock),
    .reset       (reset),
    .fetch_start (fetch_start),
    .fetch_pc    (fetch_pc),
    .fetch_done  (fetch_done),
    .fetch_inst  (fetch_inst),
    .bus         (rd_fetch)
  );

  lsu_align lsu_align_inst (
    .clock     (clock),
    .reset     (reset),
    .lsu_start (lsu_start),
    .lsu_write (lsu_write),
    .lsu_func  (lsu_func),
    .lsu_addr  (lsu_addr),
    .lsu_wdata (lsu_wdata),
    .lsu_done  (lsu_done),
    .lsu_err   (lsu_err),
    .lsu_rdata (lsu_rdata),
    .rd        (rd_lsu),
    .wr        (wr_lsu)
  );

  bus_arbiter bus_arbiter_inst (
    .clock      (clock),
    .reset      (reset),
    .fetch_port (rd_fetch),
    .lsu_port   (rd_lsu),
    .bus        (rd_bus)
  );

  addr_xbar addr_xbar_inst (
    .clock    (clock),
    .reset    (reset),
    .rd_in    (rd_bus),
    .wr_in    (wr_lsu),
    .rd_ext   (rd_ext),
    .wr_ext   (wr_ext),
    .rd_clint (rd_clint)
  );

  clint_timer #(
    .MTIME_WIDTH (MTIME_WIDTH)
  ) clint_timer_inst (
    .clock (clock),
    .reset (reset),
    .bus   (rd_clint)
  );

  // external read channels
  assign m_arvalid      = rd_ext.arvalid;
  assign m_araddr       = rd_ext.araddr;
  assign m_rready       = rd_ext.rready;
  assign rd_ext.arready = m_arready;
  assign rd_ext.rvalid  = m_rvalid;
  assign rd_ext.rdata   = m_rdata;
  assign rd_ext.rresp   = m_rresp;

  // external write channels
  assign m_awvalid      = wr_ext.awvalid;
  assign m_awaddr       = wr_ext.awaddr;
  assign m_wvalid       = wr_ext.wvalid;
  assign m_wdata        = wr_ext.wdata;
  assign m_wstrb        = wr_ext.wstrb;
  assign m_bready       = wr_ext.bready;
  assign wr_ext.awready = m_awready;
  assign wr_ext.wready  = m_wready;
  assign wr_ext.bvalid  = m_bvalid;
  assign wr_ext.bresp   = m_bresp;

endmodule
